// File: src/calc_params.svh
`ifndef calc_params_svh
`define calc_params_svh

// two decimal digits per operand
`define calc_operand_w 8

// four BCD digits on the left display
`define calc_result_w 16

// saved results
`define calc_store_depth 4

// about 1 ms of stable level at 100 MHz
`define calc_debounce_default 100000

`endif

// File: src/calc_pkg.sv
`include "calc_params.svh"

package calc_pkg;

  // digits 0 to 9 and operators a to d
  typedef logic [3:0] key_code_t;

  // order follows the key codes a, b, c, d
  typedef enum logic [1:0] {
    op_add,
    op_sub,
    op_mul,
    op_div
  } op_t;

  typedef struct packed {
    logic      valid;
    key_code_t code;
  } key_event_t;

  // digit entry states for operand a, then operand b
  typedef enum logic [2:0] {
    st_idle,
    st_a_one,
    st_a_two,
    st_op_set,
    st_b_one,
    st_b_two,
    st_result
  } calc_state_t;

  typedef enum logic [2:0] {
    act_none,
    act_clear,
    act_load_a,
    act_append_a,
    act_set_op,
    act_load_b,
    act_append_b,
    act_commit
  } calc_action_t;

  typedef logic [`calc_operand_w-1:0] operand_t;
  typedef logic [`calc_result_w-1:0]  result_t;

endpackage

// File: src/display_pkg.sv
package display_pkg;

  // one decimal digit, 0 to 9
  typedef logic [3:0] bcd_digit_t;

  // four digits of one display
  // most significant digit first
  typedef struct packed {
    bcd_digit_t thousands;
    bcd_digit_t hundreds;
    bcd_digit_t tens;
    bcd_digit_t ones;
  } display_word_t;

endpackage

// File: src/key_debounce.sv
`timescale 1ns/1ps
`include "calc_params.svh"

module key_debounce #(
  parameter int stable_cycles = `calc_debounce_default
) (
  input  logic clk,
  input  logic rst_n,
  input  logic button,
  output logic press
);

  localparam int timer_w = $clog2(stable_cycles);
  localparam logic [timer_w-1:0] timer_last = timer_w'(stable_cycles - 1);

  logic [timer_w-1:0] timer;
  logic               level;
  logic               level_q;

  // timer runs only while the raw input disagrees with the filtered level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer <= '0;
      level <= 1'b0;
    end else if (button != level) begin
      if (timer == timer_last) begin
        level <= button;
        timer <= '0;
      end else begin
        timer <= timer + 1'b1;
      end
    end else begin
      // bounce back to the old level restarts the wait
      timer <= '0;
    end
  end

  // one cycle pulse on the rising filtered level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= 1'b0;
      press   <= 1'b0;
    end else begin
      level_q <= level;
      press   <= level & ~level_q;
    end
  end

endmodule

// File: src/calc_fsm.sv
`timescale 1ns/1ps

module calc_fsm import calc_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  key_event_t   key,
  input  logic         equals,
  input  logic         save,
  output calc_action_t action,
  output op_t          op,
  output key_code_t    digit,
  output logic         store_write
);

  calc_state_t  state;
  calc_state_t  state_next;
  calc_action_t action_next;
  logic         is_digit;
  logic         is_oper;
  key_code_t    op_offset;

  // key classification
  assign is_digit  = key.valid && (key.code <= 4'd9);
  assign is_oper   = key.valid && (key.code >= 4'ha) && (key.code <= 4'hd);
  assign op_offset = key.code - 4'ha;

  // equals wins over a key in the same cycle
  always_comb begin
    state_next  = state;
    action_next = act_none;
    if (equals) begin
      case (state)
        // single digit is already the answer
        st_a_one: state_next = st_result;
        st_a_two, st_b_one, st_b_two: begin
          state_next  = st_result;
          action_next = act_commit;
        end
        st_op_set: begin
          state_next  = st_idle;
          action_next = act_clear;
        end
        default: ;
      endcase
    end else if (is_oper) begin
      if (state inside {st_a_one, st_a_two, st_result}) begin
        state_next  = st_op_set;
        action_next = act_set_op;
      end
    end else if (is_digit) begin
      case (state)
        st_idle, st_result: begin
          state_next  = st_a_one;
          action_next = act_load_a;
        end
        st_a_one: begin
          state_next  = st_a_two;
          action_next = act_append_a;
        end
        st_op_set: begin
          state_next  = st_b_one;
          action_next = act_load_b;
        end
        st_b_one: begin
          state_next  = st_b_two;
          action_next = act_append_b;
        end
        // third digit of an operand is dropped
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      action      <= act_none;
      store_write <= 1'b0;
    end else begin
      state       <= state_next;
      action      <= action_next;
      store_write <= save && (state == st_result);
    end
  end

  // key payload lines up with the registered action
  always_ff @(posedge clk) begin
    if (is_digit) begin
      digit <= key.code;
    end
    if (is_oper) begin
      op <= op_t'(op_offset[1:0]);
    end
  end

endmodule

// File: src/calc_datapath.sv
`timescale 1ns/1ps

module calc_datapath import calc_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  calc_action_t action,
  input  op_t          op,
  input  key_code_t    digit,
  output result_t      result,
  output result_t      last_result
);

  operand_t a;
  operand_t b;
  op_t      op_q;

  // arithmetic unit
  always_comb begin
    case (op_q)
      op_add: result = result_t'(a) + result_t'(b);
      // wraps in 16 bits when b > a
      op_sub: result = result_t'(a) - result_t'(b);
      op_mul: result = result_t'(a) * result_t'(b);
      // division, zero divisor gives 0
      default: result = (b == '0) ? '0 : result_t'(a / b);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a           <= '0;
      b           <= '0;
      op_q        <= op_add;
      last_result <= '0;
    end else begin
      case (action)
        act_clear: begin
          a    <= '0;
          b    <= '0;
          op_q <= op_add;
        end
        // new entry starts as a + 0
        act_load_a: begin
          a    <= operand_t'(digit);
          b    <= '0;
          op_q <= op_add;
        end
        act_append_a: a <= operand_t'(a * 10 + digit);
        act_set_op:   op_q <= op;
        act_load_b:   b <= operand_t'(digit);
        act_append_b: b <= operand_t'(b * 10 + digit);
        act_commit: begin
          last_result <= result;
          // last two decimal digits feed a chained operation
          a <= operand_t'(result % 100);
        end
        default: ;
      endcase
    end
  end

endmodule

// File: src/display_formatter.sv
`timescale 1ns/1ps

module display_formatter import calc_pkg::*, display_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  calc_action_t  action,
  input  op_t           op,
  input  key_code_t     digit,
  input  result_t       result,
  input  result_t       stored,
  output display_word_t out1,
  output display_word_t out2
);

  key_code_t op_code;
  key_code_t shift_nibble;

  // thousands digit wraps modulo 10
  function automatic display_word_t to_bcd(input result_t value);
    display_word_t word;
    word.thousands = bcd_digit_t'((value / 1000) % 10);
    word.hundreds  = bcd_digit_t'((value / 100) % 10);
    word.tens      = bcd_digit_t'((value / 10) % 10);
    word.ones      = bcd_digit_t'(value % 10);
    return word;
  endfunction

  // operator shown as its key code a to d
  assign op_code      = 4'ha + {2'b00, op};
  assign shift_nibble = (action == act_set_op) ? op_code : digit;

  // left display
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out1 <= '0;
    end else begin
      case (action)
        act_clear:  out1 <= '0;
        act_load_a: out1 <= display_word_t'({12'h000, digit});
        act_append_a, act_set_op, act_load_b, act_append_b: begin
          out1 <= {out1.hundreds, out1.tens, out1.ones, shift_nibble};
        end
        act_commit: out1 <= to_bcd(result);
        default: ;
      endcase
    end
  end

  // right display follows the selected memory page
  assign out2 = to_bcd(stored);

endmodule

// File: src/result_store.sv
`timescale 1ns/1ps
`include "calc_params.svh"

module result_store import calc_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    write,
  input  result_t data,
  input  logic    page_up,
  input  logic    page_down,
  output result_t read
);

  localparam int depth = `calc_store_depth;
  localparam int ptr_w = $clog2(depth);
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(depth - 1);

  result_t          mem [depth];
  logic [depth-1:0] filled;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] page;

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr] <= data;
    end
  end

  // round robin write slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      filled <= '0;
    end else if (write) begin
      filled[wr_ptr] <= 1'b1;
      wr_ptr         <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
    end
  end

  // page up counts down, page down counts up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      page <= '0;
    end else if (page_up && !page_down) begin
      page <= (page == '0) ? ptr_last : page - 1'b1;
    end else if (page_down && !page_up) begin
      page <= (page == ptr_last) ? '0 : page + 1'b1;
    end
  end

  // empty slots read as zero
  assign read = filled[page] ? mem[page] : '0;

endmodule

// File: src/calc_top.sv
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_top import calc_pkg::*, display_pkg::*; #(
  parameter int debounce_cycles = `calc_debounce_default
) (
  input  logic          clk,
  input  logic          rst_n,
  input  key_event_t    key,
  input  logic          equals,
  input  logic          save,
  input  logic          page_up,
  input  logic          page_down,
  output display_word_t out1,
  output display_word_t out2
);

  logic         save_press;
  logic         page_up_press;
  logic         page_down_press;
  calc_action_t action;
  op_t          op;
  key_code_t    digit;
  logic         store_write;
  result_t      result;
  result_t      last_result;
  result_t      stored;

  // button filters
  key_debounce #(.stable_cycles(debounce_cycles)) save_db0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .button (save),
    .press  (save_press)
  );

  key_debounce #(.stable_cycles(debounce_cycles)) page_up_db0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .button (page_up),
    .press  (page_up_press)
  );

  key_debounce #(.stable_cycles(debounce_cycles)) page_down_db0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .button (page_down),
    .press  (page_down_press)
  );

  calc_fsm fsm0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .key         (key),
    .equals      (equals),
    .save        (save_press),
    .action      (action),
    .op          (op),
    .digit       (digit),
    .store_write (store_write)
  );

  calc_datapath datapath0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .action      (action),
    .op          (op),
    .digit       (digit),
    .result      (result),
    .last_result (last_result)
  );

  display_formatter formatter0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .action (action),
    .op     (op),
    .digit  (digit),
    .result (result),
    .stored (stored),
    .out1   (out1),
    .out2   (out2)
  );

  result_store store0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .write     (store_write),
    .data      (last_result),
    .page_up   (page_up_press),
    .page_down (page_down_press),
    .read      (stored)
  );

endmodule

// File: verification/calc_tb.sv
`timescale 1ns/1ps

module calc_tb import calc_pkg::*, display_pkg::*; ();

  localparam int debounce = 8;
  // all six tests need well under 1000 cycles
  localparam int max_cycles = 4000;

  typedef enum {m_idle, m_a_one, m_a_two, m_op_set, m_b_one, m_b_two, m_result} entry_t;

  logic          clk;
  logic          rst_n;
  key_event_t    key;
  logic          equals;
  logic          save;
  logic          page_up;
  logic          page_down;
  display_word_t out1;
  display_word_t out2;

  // reference model of entry state, operands, left display and memory
  entry_t        m_state = m_idle;
  logic [7:0]    m_a = '0;
  logic [7:0]    m_b = '0;
  logic [1:0]    m_op = '0;
  logic [15:0]   m_last = '0;
  logic [15:0]   m_disp = '0;
  logic [15:0]   m_slot [4] = '{default: '0};
  logic [1:0]    m_wr = '0;
  logic [1:0]    m_page = '0;

  logic          key_sent;
  int            cycles = 0;
  int            tests = 0;
  int            imm_errors = 0;
  int            prop_errors = 0;

  calc_top #(.debounce_cycles(debounce)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, stimulus did not finish", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // out1 settles on the second edge after the event is sampled
  out1_check: assert property (@(posedge clk) disable iff (!rst_n)
    $past(key_sent, 2) |-> out1 == m_disp)
    else begin
      $display("Fail out1: expected %h, actual %h", $sampled(m_disp), $sampled(out1));
      prop_errors++;
    end

  function automatic logic [15:0] bcd(input logic [15:0] v);
    return {4'((v / 1000) % 10), 4'((v / 100) % 10), 4'((v / 10) % 10), 4'(v % 10)};
  endfunction

  function automatic logic [15:0] compute(input logic [7:0] a, input logic [7:0] b,
                                          input logic [1:0] op);
    case (op)
      2'd0: return 16'(a) + 16'(b);
      2'd1: return 16'(a) - 16'(b);
      2'd2: return 16'(a) * 16'(b);
      default: return (b == 8'd0) ? 16'd0 : 16'(a / b);
    endcase
  endfunction

  task automatic check_word(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    assert (actual == expected)
    else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      imm_errors++;
    end
  endtask

  // one key or equals event, model first, then a single cycle on the inputs
  task automatic press(input logic is_eq, input logic [3:0] code);
    if (is_eq && m_state inside {m_a_two, m_b_one, m_b_two}) begin
      m_last = compute(m_a, m_b, m_op);
      m_disp = bcd(m_last);
      m_a = 8'(m_last % 100);
      m_state = m_result;
    end else if (is_eq && m_state == m_a_one) begin
      m_state = m_result;
    end else if (is_eq && m_state == m_op_set) begin
      m_a = '0;
      m_b = '0;
      m_op = '0;
      m_disp = '0;
      m_state = m_idle;
    end else if (!is_eq && code > 4'd9 && m_state inside {m_a_one, m_a_two, m_result}) begin
      m_op = 2'(code - 4'ha);
      m_disp = {m_disp[11:0], code};
      m_state = m_op_set;
    end else if (!is_eq && code <= 4'd9 && m_state inside {m_idle, m_result}) begin
      m_a = 8'(code);
      m_b = '0;
      m_op = '0;
      m_disp = {12'h000, code};
      m_state = m_a_one;
    end else if (!is_eq && code <= 4'd9 && m_state inside {m_a_one, m_op_set, m_b_one}) begin
      if (m_state == m_a_one)
        m_a = 8'(m_a * 10 + code);
      else
        m_b = (m_state == m_op_set) ? 8'(code) : 8'(m_b * 10 + code);
      m_disp = {m_disp[11:0], code};
      m_state = m_state.next();
    end
    key = {!is_eq, code};
    equals = is_eq;
    key_sent = 1'b1;
    @(posedge clk);
    #2;
    key = '0;
    equals = 1'b0;
    key_sent = 1'b0;
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic calculate(input int a, input int op, input int b);
    press(1'b0, 4'(a / 10));
    press(1'b0, 4'(a % 10));
    press(1'b0, 4'(10 + op));
    press(1'b0, 4'(b / 10));
    press(1'b0, 4'(b % 10));
    press(1'b1, 4'h0);
  endtask

  // sel 0 save, 1 page up, 2 page down
  task automatic press_button(input int sel, input int hold);
    save = (sel == 0);
    page_up = (sel == 1);
    page_down = (sel == 2);
    repeat (hold) @(posedge clk);
    #2;
    save = 1'b0;
    page_up = 1'b0;
    page_down = 1'b0;
    // only a level held for the whole filter time counts
    if (hold >= debounce) begin
      if (sel == 0 && m_state == m_result) begin
        m_slot[m_wr] = m_last;
        m_wr = m_wr + 2'd1;
      end else if (sel == 1) begin
        m_page = m_page - 2'd1;
      end else if (sel == 2) begin
        m_page = m_page + 2'd1;
      end
    end
    repeat (debounce + 6) @(posedge clk);
    #2;
    check_word("out2", out2, bcd(m_slot[m_page]));
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s done, errors so far %0d", tests, name, imm_errors + prop_errors);
  endtask

  initial begin
    void'($urandom(78));
    rst_n = 1'b0;
    key = '0;
    equals = 1'b0;
    save = 1'b0;
    page_up = 1'b0;
    page_down = 1'b0;
    key_sent = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_word("out1", out1, 16'h0000);
    check_word("out2", out2, 16'h0000);
    end_test("reset");

    // third digit of each operand is dropped
    press(1'b0, 4'd4);
    press(1'b0, 4'd7);
    press(1'b0, 4'd2);
    press(1'b0, 4'hc);
    press(1'b0, 4'd1);
    press(1'b0, 4'd3);
    press(1'b0, 4'd9);
    press(1'b1, 4'h0);
    press(1'b0, 4'd6);
    press(1'b1, 4'h0);
    press(1'b0, 4'ha);
    press(1'b1, 4'h0);
    end_test("digit entry");

    for (int op = 0; op < 4; op++) begin
      repeat (3) calculate($urandom_range(99), op, $urandom_range(99));
    end
    calculate(12, 1, 57);
    calculate(45, 3, 0);
    end_test("arithmetic");

    repeat (3) begin
      calculate($urandom_range(99), $urandom_range(3), $urandom_range(99));
      press(1'b0, 4'(10 + $urandom_range(3)));
      press(1'b0, 4'($urandom_range(9)));
      press(1'b0, 4'($urandom_range(9)));
      press(1'b1, 4'h0);
    end
    end_test("chained result");

    for (int i = 0; i < 5; i++) begin
      calculate(10 + i, 2, 3);
      press_button(0, 12);
    end
    press_button(1, 12);
    press_button(1, 12);
    press_button(2, 12);
    press_button(2, 12);
    press_button(2, 12);
    // save while entering a new operand
    press(1'b0, 4'd5);
    press_button(0, 12);
    end_test("result memory");

    press(1'b1, 4'h0);
    press_button(0, 5);
    press_button(2, 3);
    press_button(1, 7);
    end_test("short pulses");

    $display("%0d tests run, %0d errors", tests, imm_errors + prop_errors);
    if (imm_errors + prop_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+src
src/calc_pkg.sv
src/display_pkg.sv
src/key_debounce.sv
src/calc_fsm.sv
src/calc_datapath.sv
src/display_formatter.sv
src/result_store.sv
src/calc_top.sv
verification/calc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= calc_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
